// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen    = 32;
    localparam int nregs   = 32;            // x0..x31
    localparam int shamt_w = $clog2(xlen);  // shift amount bits

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] f3_add  = 3'b000;  // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;  // srl and sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 for branches
    localparam logic [2:0] f3_beq   = 3'b000;
    localparam logic [2:0] f3_bne   = 3'b001;
    localparam logic [2:0] f3_blt   = 3'b100;
    localparam logic [2:0] f3_bge   = 3'b101;
    localparam logic [2:0] f3_bltu  = 3'b110;
    localparam logic [2:0] f3_bge_u = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra, srai

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    // R-type view of an instruction word, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_t;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;    // operand b from imm
        logic       use_pc;     // operand a from pc
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        logic       rd_we;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] br_f3;
    } decoded_t;

endpackage

// File: src/core_bus_pkg.sv
package core_bus_pkg;

    // first fetch address out of reset
    localparam rv_isa_pkg::word_t reset_pc = 32'h0000_0000;

    // wishbone classic master side, read only so no we/sel/dat_o
    typedef struct packed {
        logic              cyc;
        logic              stb;
        rv_isa_pkg::word_t adr;
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic              ack;
        rv_isa_pkg::word_t dat;
    } wb_rsp_t;

    // one record per executed instruction
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::word_t     pc;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     wdata;   // result or link value
        logic                  we;      // rd write enabled
    } retire_t;

endpackage

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,
    output core_bus_pkg::wb_req_t wb_o,
    input  core_bus_pkg::wb_rsp_t wb_i,
    input  rv_isa_pkg::word_t     next_pc,
    output rv_isa_pkg::word_t     instr,
    output logic                  instr_valid,
    output rv_isa_pkg::word_t     pc,
    output logic                  halted
);
    import rv_isa_pkg::*;
    import core_bus_pkg::*;

    typedef enum logic [1:0] {st_req, st_exec, st_halt} state_e;

    state_e state;
    logic   stb_q;      // drives both cyc and stb
    logic   ack_fire;   // slave answered our open request

    assign ack_fire = (state == st_req) && stb_q && wb_i.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_req;
            stb_q <= 1'b0;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_req: begin
                    if (!stb_q) begin
                        stb_q <= 1'b1;                  // first request after reset
                    end else if (wb_i.ack) begin
                        stb_q <= 1'b0;                  // drop cyc/stb after ack
                        state <= (wb_i.dat == '0) ? st_halt : st_exec;
                    end
                end
                st_exec: begin
                    pc    <= next_pc;                   // commit pc with the reg write
                    stb_q <= 1'b1;                      // next fetch right after
                    state <= st_req;
                end
                default: state <= st_halt;              // halt until reset
            endcase
        end
    end

    // instruction register, only meaningful while instr_valid
    always_ff @(posedge clk) begin
        if (ack_fire) begin
            instr <= wb_i.dat;
        end
    end

    assign wb_o        = '{cyc: stb_q, stb: stb_q, adr: pc};  // adr stable during fetch
    assign instr_valid = (state == st_exec);
    assign halted      = (state == st_halt);

endmodule

// File: src/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  rv_isa_pkg::word_t    instr,
    output rv_isa_pkg::decoded_t dec
);
    import rv_isa_pkg::*;

    instr_t  f;
    word_t   imm_i;
    word_t   imm_b;
    word_t   imm_j;
    word_t   imm_u;
    alu_op_e f3_op;     // alu op picked by funct3 alone
    logic    is_alt;    // funct7 asks for sub / sra
    logic    alt_ok;    // funct3 values where alt funct7 is legal
    logic    shift_f3;  // shifts carry funct7 in OP-IMM too

    assign f = instr_t'(instr);

    // immediates, all sign extended from bit 31 except U
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    assign is_alt   = (f.funct7 == f7_alt);
    assign alt_ok   = (f.funct3 == f3_add) || (f.funct3 == f3_sr);
    assign shift_f3 = (f.funct3 == f3_sll) || (f.funct3 == f3_sr);

    always_comb begin
        case (f.funct3)
            f3_add:  f3_op = alu_add;
            f3_sll:  f3_op = alu_sll;
            f3_slt:  f3_op = alu_slt;
            f3_sltu: f3_op = alu_sltu;
            f3_xor:  f3_op = alu_xor;
            f3_sr:   f3_op = is_alt ? alu_sra : alu_srl;
            f3_or:   f3_op = alu_or;
            default: f3_op = alu_and;
        endcase
    end

    always_comb begin
        dec        = '0;            // unknown opcode: no write, no jump
        dec.alu_op = alu_add;
        dec.rd     = f.rd;
        dec.rs1    = f.rs1;
        dec.rs2    = f.rs2;
        dec.imm    = imm_i;
        dec.br_f3  = f.funct3;
        case (f.opcode)
            op_imm: begin
                dec.use_imm = 1'b1;
                dec.alu_op  = f3_op;
                // slli/srli/srai need a clean funct7, srai only on sr
                dec.rd_we   = !shift_f3 || (f.funct7 == f7_base)
                              || (is_alt && f.funct3 == f3_sr);
            end
            op_reg: begin
                dec.alu_op = (f.funct3 == f3_add && is_alt) ? alu_sub : f3_op;
                dec.rd_we  = (f.funct7 == f7_base) || (is_alt && alt_ok);
            end
            op_lui: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = alu_pass_b;
                dec.rd_we   = 1'b1;
            end
            op_auipc: begin
                dec.use_imm = 1'b1;
                dec.use_pc  = 1'b1;
                dec.imm     = imm_u;    // pc + (imm << 12)
                dec.rd_we   = 1'b1;
            end
            op_jal: begin
                dec.imm    = imm_j;
                dec.is_jal = 1'b1;
                dec.rd_we  = 1'b1;      // link
            end
            op_jalr: begin
                dec.is_jalr = 1'b1;     // target from rs1 + imm_i
                dec.rd_we   = 1'b1;
            end
            op_branch: begin
                dec.imm       = imm_b;
                dec.is_branch = (f.funct3[2:1] != 2'b01);  // 010 and 011 are reserved
            end
            default: dec.rd_we = 1'b0;
        endcase
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_isa_pkg::reg_addr_t raddr_a,
    input  rv_isa_pkg::reg_addr_t raddr_b,
    output rv_isa_pkg::word_t     rdata_a,
    output rv_isa_pkg::word_t     rdata_b,
    input  logic                  we,
    input  rv_isa_pkg::reg_addr_t waddr,
    input  rv_isa_pkg::word_t     wdata
);
    import rv_isa_pkg::*;

    word_t regs [nregs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin   // x0 is hardwired
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  rv_isa_pkg::decoded_t  dec,
    input  logic                  instr_valid,
    input  rv_isa_pkg::word_t     pc,
    input  rv_isa_pkg::word_t     rdata_a,
    input  rv_isa_pkg::word_t     rdata_b,
    output rv_isa_pkg::reg_addr_t raddr_a,
    output rv_isa_pkg::reg_addr_t raddr_b,
    output logic                  we,
    output rv_isa_pkg::reg_addr_t waddr,
    output rv_isa_pkg::word_t     wdata,
    output rv_isa_pkg::word_t     next_pc,
    output core_bus_pkg::retire_t retire_o
);
    import rv_isa_pkg::*;

    word_t            op_a;
    word_t            op_b;
    word_t            alu_res;
    word_t            link;       // pc + 4
    word_t            br_target;  // pc + imm, shared by jal and branches
    logic [shamt_w-1:0] shamt;
    logic             taken;

    assign raddr_a   = dec.rs1;
    assign raddr_b   = dec.rs2;
    assign op_a      = dec.use_pc ? pc : rdata_a;
    assign op_b      = dec.use_imm ? dec.imm : rdata_b;
    assign shamt     = op_b[shamt_w-1:0];   // only low 5 bits count
    assign link      = pc + 32'd4;
    assign br_target = pc + dec.imm;

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_sll:    alu_res = op_a << shamt;
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:    alu_res = op_a ^ op_b;
            alu_srl:    alu_res = op_a >> shamt;
            alu_sra:    alu_res = word_t'($signed(op_a) >>> shamt);
            alu_or:     alu_res = op_a | op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_pass_b: alu_res = op_b;           // lui
            default:    alu_res = '0;
        endcase
    end

    // compare on this instruction's operands
    always_comb begin
        case (dec.br_f3)
            f3_beq:   taken = (rdata_a == rdata_b);
            f3_bne:   taken = (rdata_a != rdata_b);
            f3_blt:   taken = ($signed(rdata_a) < $signed(rdata_b));
            f3_bge:   taken = ($signed(rdata_a) >= $signed(rdata_b));
            f3_bltu:  taken = (rdata_a < rdata_b);
            f3_bge_u: taken = (rdata_a >= rdata_b);
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        if (dec.is_jal) begin
            next_pc = br_target;
        end else if (dec.is_jalr) begin
            next_pc = (rdata_a + dec.imm) & ~word_t'(1);  // clear bit 0
        end else if (dec.is_branch && taken) begin
            next_pc = br_target;
        end else begin
            next_pc = link;     // includes unknown opcodes
        end
    end

    assign we    = instr_valid & dec.rd_we;
    assign waddr = dec.rd;
    assign wdata = (dec.is_jal || dec.is_jalr) ? link : alu_res;

    assign retire_o = '{valid: instr_valid, pc: pc, rd: dec.rd, wdata: wdata, we: we};

endmodule

// File: src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  rst,
    output core_bus_pkg::wb_req_t wb_o,
    input  core_bus_pkg::wb_rsp_t wb_i,
    output core_bus_pkg::retire_t retire_o,
    output logic                  halted
);
    import rv_isa_pkg::*;

    word_t     instr;
    word_t     pc;
    word_t     next_pc;
    logic      instr_valid;   // single execute cycle per instruction
    decoded_t  dec;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .wb_o        (wb_o),
        .wb_i        (wb_i),
        .next_pc     (next_pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .halted      (halted)
    );

    rv_decoder u_dec (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    exec_unit u_exec (
        .dec         (dec),
        .instr_valid (instr_valid),
        .pc          (pc),
        .rdata_a     (rdata_a),
        .rdata_b     (rdata_b),
        .raddr_a     (raddr_a),
        .raddr_b     (raddr_b),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .next_pc     (next_pc),
        .retire_o    (retire_o)
    );

endmodule

// File: verif/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
    input logic                  clk,
    input logic                  rst,
    input core_bus_pkg::wb_req_t wb_o,
    input core_bus_pkg::wb_rsp_t wb_i,
    input core_bus_pkg::retire_t retire_o,
    input logic                  halted
);
    // stb only inside a cycle
    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_o.stb |-> wb_o.cyc)
        else $error("wishbone stb high without cyc");

    // back-pressure holds the request as it is
    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr)))
        else $error("wishbone request changed before ack");

    a_retire_once: assert property (@(posedge clk) disable iff (rst)
        retire_o.valid |=> !retire_o.valid)
        else $error("retire valid lasted two cycles");

    // halt is final until reset
    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        halted |-> (!wb_o.cyc && !wb_o.stb && !retire_o.valid))
        else $error("bus request or retire while halted");

endmodule

bind rv_core_top rv_core_assertions u_assert (
    .clk      (clk),
    .rst      (rst),
    .wb_o     (wb_o),
    .wb_i     (wb_i),
    .retire_o (retire_o),
    .halted   (halted)
);

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
    import rv_isa_pkg::*;
    import core_bus_pkg::*;

    localparam int mem_words = 64;

    logic    clk;
    logic    rst;
    wb_req_t wb_o;
    wb_rsp_t wb_i;
    retire_t retire_o;
    logic    halted;

    word_t   mem [mem_words];   // program memory, word addressed
    int      wr_ptr;            // next free program slot
    int      max_wait;          // slave inserts 0..max_wait wait states
    int      wait_cnt;
    word_t   rng = 32'd56;
    logic    req_seen;
    logic    rst_seen;
    int      errors;
    int      checks;
    retire_t ret_q[$];          // retired by the core
    word_t   adr_q[$];          // acked fetch addresses
    retire_t exp_q[$];          // model records
    word_t   exp_npc[$];        // model next pc per record
    retire_t base_q[$];         // zero wait reference run

    rv_core_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .wb_o     (wb_o),
        .wb_i     (wb_i),
        .retire_o (retire_o),
        .halted   (halted)
    );

    always #20 clk = ~clk;

    // wishbone slave, inputs change 1 ns after the edge
    always @(posedge clk) begin
        req_seen = wb_o.cyc && wb_o.stb;
        rst_seen = rst;
        #1;
        if (rst_seen || wb_i.ack) begin
            wb_i.ack = 1'b0;                    // ack lasts one cycle
            if (rst_seen) begin
                wait_cnt = 0;
            end
        end else if (req_seen) begin
            if (wait_cnt > 0) begin
                wait_cnt--;                     // still stalling
            end else begin
                wb_i.ack = 1'b1;
                wb_i.dat = mem[wb_o.adr[7:2]];
                wait_cnt = (max_wait > 0) ? int'(next_rand() % word_t'(max_wait + 1)) : 0;
            end
        end
    end

    // collect retires and fetch addresses
    always @(posedge clk) begin
        if (!rst && retire_o.valid) begin
            ret_q.push_back(retire_o);
        end
        if (!rst && wb_o.stb && wb_i.ack) begin
            adr_q.push_back(wb_o.adr);
        end
    end

    function automatic word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // instruction encoders
    function automatic word_t enc_i(word_t imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic word_t enc_u(word_t imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_b(word_t off, int rs1, int rs2, logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic word_t enc_j(word_t off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
    endfunction

    // isa results, alt = sub or arithmetic shift
    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // instruction set model over mem, fills exp_q and exp_npc
    task automatic ref_run();
        word_t x [32];
        word_t pc, ins, a, b, imm, res, npc;
        logic  we;
        x = '{default: '0};
        pc = reset_pc;
        exp_q.delete();
        exp_npc.delete();
        for (int s = 0; s < 200; s++) begin
            ins = mem[pc[7:2]];
            if (ins == '0) begin
                break;                          // halt word
            end
            a   = x[ins[19:15]];
            b   = x[ins[24:20]];
            imm = {{20{ins[31]}}, ins[31:20]};
            res = '0;
            we  = 1'b1;
            npc = pc + 32'd4;
            case (ins[6:0])
                op_imm:   res = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm);
                op_reg:   res = alu_ref(ins[14:12], ins[30], a, b);
                op_lui:   res = {ins[31:12], 12'b0};
                op_auipc: res = pc + {ins[31:12], 12'b0};
                op_jal: begin
                    res = pc + 32'd4;
                    npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                op_jalr: begin
                    res = pc + 32'd4;
                    npc = (a + imm) & ~32'd1;   // bit 0 dropped
                end
                op_branch: begin
                    we = 1'b0;
                    if (br_ref(ins[14:12], a, b)) begin
                        npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                default:  we = 1'b0;            // unknown opcode
            endcase
            if (we && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            exp_q.push_back('{valid: 1'b1, pc: pc, rd: ins[11:7], wdata: res, we: we});
            exp_npc.push_back(npc);
            pc = npc;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check(string name, word_t exp, word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic clear_prog();
        foreach (mem[i]) begin
            mem[i] = '0;                        // unused words halt the core
        end
        wr_ptr = 0;
    endtask

    task automatic emit(word_t w);
        mem[wr_ptr] = w;
        wr_ptr++;
    endtask

    // lui + addi pair for any 32-bit value
    task automatic load_imm(int rd, word_t v);
        emit(enc_u((v + 32'h800) >> 12, rd, op_lui));
        emit(enc_i(v, rd, f3_add, rd, op_imm));
    endtask

    // reset, run to the halt word, then watch a quiet window
    task automatic run_program(int waits);
        int n;
        max_wait = waits;
        tick();
        rst = 1'b1;
        ret_q.delete();
        adr_q.delete();
        repeat (2) tick();
        rst = 1'b0;
        for (n = 0; n < 2000 && !halted; n++) begin
            tick();
        end
        if (!halted) begin
            errors++;
            $display("timeout: core did not reach the halt word within 2000 cycles");
        end else begin
            n = ret_q.size();
            repeat (20) begin
                tick();
                if (wb_o.cyc || wb_o.stb) begin
                    errors++;
                    $display("bus request seen after the core halted");
                end
            end
            if (ret_q.size() != n) begin
                errors++;
                $display("instruction retired after the core halted");
            end
        end
    endtask

    task automatic compare_run(string tag);
        check({tag, " retire count"}, 32'(exp_q.size()), 32'(ret_q.size()));
        for (int i = 0; i < exp_q.size() && i < ret_q.size(); i++) begin
            check($sformatf("%s #%0d retire_o.pc", tag, i), exp_q[i].pc, ret_q[i].pc);
            check($sformatf("%s #%0d retire_o.rd", tag, i), 32'(exp_q[i].rd), 32'(ret_q[i].rd));
            check($sformatf("%s #%0d retire_o.we", tag, i), 32'(exp_q[i].we), 32'(ret_q[i].we));
            if (exp_q[i].we) begin
                check($sformatf("%s #%0d retire_o.wdata", tag, i), exp_q[i].wdata,
                      ret_q[i].wdata);
            end
            if (i + 1 < adr_q.size()) begin
                check($sformatf("%s #%0d wb_o.adr", tag, i), exp_npc[i], adr_q[i+1]);
            end else begin
                errors++;
                $display("%s: no fetch followed instruction %0d", tag, i);
            end
        end
    endtask

    task automatic model_and_run(string tag, int waits);
        ref_run();
        run_program(waits);
        compare_run(tag);
    endtask

    task automatic test_op_imm();
        clear_prog();
        load_imm(1, 32'h8765_4321);
        load_imm(2, 32'h0000_0ffb);
        emit(enc_i(-1, 1, f3_add, 3, op_imm));
        emit(enc_i(5, 1, f3_slt, 4, op_imm));       // negative < 5
        emit(enc_i(5, 1, f3_sltu, 5, op_imm));      // huge unsigned
        emit(enc_i(-1, 2, f3_slt, 6, op_imm));
        emit(enc_i(-1, 2, f3_sltu, 7, op_imm));
        emit(enc_i(-1, 1, f3_xor, 8, op_imm));
        emit(enc_i(32'h5a0, 2, f3_or, 9, op_imm));
        emit(enc_i(32'h7f0, 1, f3_and, 10, op_imm));
        emit(enc_i(7, 1, f3_sll, 11, op_imm));
        emit(enc_i(31, 1, f3_sr, 12, op_imm));
        emit(enc_i(32'h404, 1, f3_sr, 13, op_imm)); // srai 4
        emit(enc_i(32'h41f, 1, f3_sr, 14, op_imm)); // srai 31
        model_and_run("op_imm", 0);
    endtask

    task automatic build_op_prog();
        clear_prog();
        load_imm(1, next_rand());
        load_imm(2, next_rand() | 32'h8000_0000);   // negative operand
        load_imm(3, next_rand() | 32'd31);          // shift amount 31
        load_imm(4, next_rand());
        emit(enc_r(f7_base, 2, 1, f3_add, 5));
        emit(enc_r(f7_alt, 2, 1, f3_add, 6));
        emit(enc_r(f7_base, 3, 1, f3_sll, 7));
        emit(enc_r(f7_base, 1, 2, f3_slt, 8));
        emit(enc_r(f7_base, 1, 2, f3_sltu, 9));
        emit(enc_r(f7_base, 4, 1, f3_xor, 10));
        emit(enc_r(f7_base, 3, 2, f3_sr, 11));
        emit(enc_r(f7_alt, 3, 2, f3_sr, 12));
        emit(enc_r(f7_base, 4, 1, f3_or, 13));
        emit(enc_r(f7_base, 4, 1, f3_and, 14));
        emit(enc_r(f7_alt, 4, 2, f3_sr, 15));
        emit(enc_r(f7_alt, 2, 2, f3_add, 16));
    endtask

    task automatic test_op_reg();
        build_op_prog();
        model_and_run("op_reg", 0);
    endtask

    // each branch three ways, taken ones skip the addi
    task automatic test_branches();
        logic [2:0] fs [6] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bge_u};
        clear_prog();
        load_imm(1, 32'hffff_ffff);
        load_imm(2, 32'h0000_0001);
        for (int k = 0; k < 6; k++) begin
            emit(enc_b(8, 1, 2, fs[k]));
            emit(enc_i(1, 20, f3_add, 20, op_imm));
            emit(enc_b(8, 2, 1, fs[k]));
            emit(enc_i(1, 20, f3_add, 20, op_imm));
            emit(enc_b(8, 1, 1, fs[k]));
            emit(enc_i(1, 20, f3_add, 20, op_imm));
        end
        model_and_run("branch", 0);
    endtask

    task automatic test_jumps();
        clear_prog();
        emit(enc_u(32'h12345, 1, op_auipc));
        emit(enc_u(32'hfffff, 2, op_lui));
        emit(enc_j(8, 3));                          // over word 3
        emit(enc_i(1, 0, f3_add, 9, op_imm));
        emit(enc_i(29, 0, f3_add, 5, op_imm));      // odd target 29
        emit(enc_i(0, 5, 3'b000, 6, op_jalr));      // lands on 28
        emit(enc_i(2, 0, f3_add, 9, op_imm));
        emit(enc_j(8, 0));                          // link into x0
        emit(enc_i(3, 0, f3_add, 9, op_imm));
        emit(enc_r(f7_base, 6, 3, f3_add, 10));
        model_and_run("jump", 0);
    endtask

    task automatic test_edges();
        clear_prog();
        emit(enc_i(5, 0, f3_add, 0, op_imm));       // write to x0
        emit(enc_r(f7_base, 0, 0, f3_add, 5));      // x0 + x0
        emit(enc_i(-1, 0, f3_add, 6, op_imm));
        emit(32'h0012_300b);                        // custom-0, not decoded
        emit(enc_i(1, 6, f3_add, 7, op_imm));
        emit(enc_r(f7_base, 0, 6, f3_or, 0));
        emit(enc_r(f7_base, 6, 0, f3_add, 8));
        model_and_run("edge", 0);
    endtask

    task automatic test_backpressure();
        build_op_prog();
        model_and_run("no_wait", 0);
        base_q = ret_q;
        model_and_run("wait", 3);
        check("wait retire count", 32'(base_q.size()), 32'(ret_q.size()));
        for (int i = 0; i < base_q.size() && i < ret_q.size(); i++) begin
            check($sformatf("wait #%0d retire_o.pc", i), base_q[i].pc, ret_q[i].pc);
            check($sformatf("wait #%0d retire_o.wdata", i), base_q[i].wdata, ret_q[i].wdata);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wb_i     = '0;
        max_wait = 0;
        wait_cnt = 0;
        wr_ptr   = 0;
        errors   = 0;
        checks   = 0;
        test_op_imm();
        test_op_reg();
        test_branches();
        test_jumps();
        test_edges();
        test_backpressure();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: rv_core_top.f
src/rv_isa_pkg.sv
src/core_bus_pkg.sv
src/fetch_unit.sv
src/rv_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/rv_core_top.sv
verif/rv_core_assertions.sv
verif/rv_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core_top.f -o rv_core_sim &&
    ./obj_dir/rv_core_sim | tee /dev/stderr | grep -qx "Done: no errors" &&
    echo "simulation passed" || { echo "simulation failed"; exit 1; }
